// File: Makefile
TOP = exec_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: hw/alu.sv
`timescale 1ns/1ps

module alu import exec_pkg::*; (
	exec_if.alu_side ops,
	output word_t alu_result,
	output logic alu_zero, // Branch taken flag
	output logic alu_movn, // MOVN condition met
	output logic alu_wen, // Result register write enable
	output logic alu_illegal // Undefined op code
);

	always_comb begin
		alu_result = '0; // Defaults keep outputs known
		alu_zero = 1'b0;
		alu_movn = 1'b0;
		alu_wen = 1'b1;
		alu_illegal = 1'b0;

		case (ops.operation)
			OP_AND:
				alu_result = ops.a & ops.b;
			OP_OR:
				alu_result = ops.a | ops.b;
			OP_ADD:
				alu_result = ops.a + ops.b; // Signed add, wraps on overflow
			OP_ADDU:
				alu_result = ops.a + ops.b;
			OP_MOVN: begin
				if (ops.b != '0) begin // rt nonzero
					alu_result = ops.a; // rd gets rs
					alu_movn = 1'b1;
				end else begin
					alu_wen = 1'b0; // Result register holds
				end
			end
			OP_SLL:
				alu_result = ops.b << ops.shamt;
			OP_SUB: begin
				alu_result = ops.a - ops.b; // Wraps on overflow
				// equal selects BEQ, otherwise BNE
				alu_zero = ops.equal ? (ops.a == ops.b) : (ops.a != ops.b);
			end
			OP_SUBU:
				alu_result = ops.a - ops.b;
			OP_BGEZ: begin
				alu_result = {{(XLEN-1){1'b0}}, !ops.a[XLEN-1]}; // 1 when rs >= 0
				alu_zero = !ops.a[XLEN-1]; // Taken when rs >= 0
			end
			OP_SLT: begin
				if ($signed(ops.a) < $signed(ops.b))
					alu_result = 32'd1;
				else
					alu_result = 32'd0;
			end
			OP_SLTU: begin
				if (ops.a < ops.b) // Unsigned compare
					alu_result = 32'd1;
				else
					alu_result = 32'd0;
			end
			OP_SRL:
				alu_result = ops.b >> ops.shamt;
			OP_NOR:
				alu_result = ~(ops.a | ops.b);
			OP_XOR:
				alu_result = ops.a ^ ops.b;
			OP_SRA:
				alu_result = $signed(ops.b) >>> ops.shamt; // Sign fill
			OP_LUI:
				alu_result = ops.b << 16; // Immediate to upper half
			OP_SRAV:
				alu_result = $signed(ops.b) >>> ops.a[4:0]; // Variable shift from rs
			default: begin // MDU codes land here too, result unused then
				alu_result = DEADBEEF;
				alu_illegal = 1'b1;
			end
		endcase
	end

	// Sampled at the end of the start pulse, while operands are still held
	a_result_known: assert property (@(negedge ops.alu_start) !$isunknown(alu_result))
		else $error("ALU result has unknown bits at alu_start");

endmodule

// File: hw/apb_regs.sv
`timescale 1ns/1ps

module apb_regs import exec_pkg::*; (
	input logic clk,
	input logic rst,
	input addr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input word_t pwdata,
	output word_t prdata,
	output logic pready,
	output logic pslverr,
	exec_if.issue issue,
	input word_t result, // From result stage
	input word_t status
);

	word_t a_q; // Operand registers
	word_t b_q;
	op_t op_q; // Control word fields
	shamt_t shamt_q;
	logic equal_q;

	logic access; // APB access phase
	logic busy; // MDU op in flight
	logic wr_map; // Writable address
	logic rd_map; // Readable address
	logic wr_ok; // Accepted write
	logic ctrl_wr; // Accepted write to CTRL, starts an op
	op_t eff_op; // Op seen by the units this cycle
	unit_e eff_unit;

	assign access = psel && penable;
	assign busy = status[ST_BUSY];
	assign wr_map = (paddr == REG_A) || (paddr == REG_B) || (paddr == REG_CTRL);
	assign rd_map = wr_map || (paddr == REG_RESULT) || (paddr == REG_STATUS);
	assign wr_ok = access && pwrite && !busy && wr_map;
	assign ctrl_wr = wr_ok && (paddr == REG_CTRL);

	assign pready = 1'b1; // No wait states
	assign pslverr = access && (pwrite ? (busy || !wr_map) : !rd_map);

	// CTRL write data bypasses to the units so the ALU settles inside the access cycle
	always_comb begin
		eff_op = ctrl_wr ? pwdata[4:0] : op_q;
		if ((eff_op >= OP_MULT) && (eff_op <= OP_MFLO))
			eff_unit = UNIT_MDU;
		else
			eff_unit = UNIT_ALU; // Illegal codes too, ALU flags them
	end

	assign issue.a = a_q;
	assign issue.b = b_q;
	assign issue.operation = eff_op;
	assign issue.shamt = ctrl_wr ? pwdata[12:8] : shamt_q;
	assign issue.equal = ctrl_wr ? pwdata[16] : equal_q;
	assign issue.unit = eff_unit;
	assign issue.alu_start = ctrl_wr && (eff_unit == UNIT_ALU);
	assign issue.mdu_start = ctrl_wr && (eff_unit == UNIT_MDU);

	always_ff @(posedge clk) begin
		if (rst) begin
			a_q <= '0;
			b_q <= '0;
			op_q <= '0;
			shamt_q <= '0;
			equal_q <= 1'b0;
		end else if (wr_ok) begin
			case (paddr)
				REG_A: a_q <= pwdata;
				REG_B: b_q <= pwdata;
				REG_CTRL: begin
					op_q <= pwdata[4:0];
					shamt_q <= pwdata[12:8];
					equal_q <= pwdata[16];
				end
				default: ; // Not reachable, wr_map filters
			endcase
		end
	end

	always_comb begin
		case (paddr)
			REG_A: prdata = a_q;
			REG_B: prdata = b_q;
			REG_CTRL: prdata = {15'd0, equal_q, 3'd0, shamt_q, 3'd0, op_q};
			REG_RESULT: prdata = result;
			REG_STATUS: prdata = status;
			default: prdata = '0; // Unmapped reads return zero
		endcase
	end

	// Access phase always follows a setup phase
	a_setup_first: assert property (@(posedge clk) disable iff (rst)
		access |-> $past(psel && !penable))
		else $error("APB access phase without a preceding setup phase");

endmodule

// File: hw/exec_if.sv
`timescale 1ns/1ps

interface exec_if import exec_pkg::*; ();

	word_t a; // Operand A
	word_t b; // Operand B
	op_t operation; // Valid during the start pulse
	shamt_t shamt;
	logic equal; // BEQ when high, BNE when low
	unit_e unit; // Owner of the op being started
	logic alu_start; // One-cycle pulse
	logic mdu_start; // One-cycle pulse

	modport issue (output a, b, operation, shamt, equal, unit, alu_start, mdu_start);

	modport alu_side (input a, b, operation, shamt, equal, alu_start);

	modport mdu_side (input a, b, operation, mdu_start);

	modport observe (input unit, alu_start, mdu_start); // Result stage needs no operands

endinterface

// File: hw/exec_pkg.sv
package exec_pkg;

	localparam int XLEN = 32; // Data path width
	localparam int MDU_STEPS = 32; // Iterations per multiply or divide

	typedef logic [XLEN-1:0] word_t; // Operands, results, HI, LO
	typedef logic [4:0] op_t; // Operation code
	typedef logic [4:0] shamt_t; // Shift amount
	typedef logic [4:0] addr_t; // APB byte address
	typedef logic [$clog2(MDU_STEPS+1)-1:0] mdu_cnt_t; // MDU step counter, 0 to MDU_STEPS

	// ALU group, same codes as the original ALU
	localparam op_t OP_AND = 5'd0;
	localparam op_t OP_OR = 5'd1;
	localparam op_t OP_ADD = 5'd2; // Wraps, no trap
	localparam op_t OP_ADDU = 5'd3;
	localparam op_t OP_MOVN = 5'd4;
	localparam op_t OP_SLL = 5'd5;
	localparam op_t OP_SUB = 5'd6; // Also BEQ/BNE
	localparam op_t OP_SUBU = 5'd7;
	localparam op_t OP_BGEZ = 5'd8;
	localparam op_t OP_SLT = 5'd9;
	localparam op_t OP_SLTU = 5'd10;
	localparam op_t OP_SRL = 5'd11;
	localparam op_t OP_NOR = 5'd12;
	localparam op_t OP_XOR = 5'd13;
	localparam op_t OP_SRA = 5'd14;
	localparam op_t OP_LUI = 5'd15;
	localparam op_t OP_SRAV = 5'd16;
	// Multiply/divide group
	localparam op_t OP_MULT = 5'd17;
	localparam op_t OP_MULTU = 5'd18;
	localparam op_t OP_DIV = 5'd19;
	localparam op_t OP_DIVU = 5'd20;
	localparam op_t OP_MFHI = 5'd21;
	localparam op_t OP_MFLO = 5'd22;

	localparam addr_t REG_A = 5'h00; // Operand A
	localparam addr_t REG_B = 5'h04; // Operand B
	localparam addr_t REG_CTRL = 5'h08; // Op 4:0, shamt 12:8, equal 16
	localparam addr_t REG_RESULT = 5'h0C; // Read only
	localparam addr_t REG_STATUS = 5'h10; // Read only

	localparam int ST_BUSY = 0; // STATUS bit positions
	localparam int ST_ZERO = 1;
	localparam int ST_MOVN = 2;
	localparam int ST_ERROR = 3;
	localparam int ST_DONE = 4;

	localparam word_t DEADBEEF = 32'hdeadbeef; // Result of an illegal op

	typedef enum logic {
		UNIT_ALU, // Combinational, done in the start cycle
		UNIT_MDU // Iterative, sets busy
	} unit_e;

endpackage

// File: hw/exec_top.sv
`timescale 1ns/1ps

module exec_top import exec_pkg::*; (
	input logic clk,
	input logic rst,
	input addr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input word_t pwdata,
	output word_t prdata,
	output logic pready,
	output logic pslverr
);

	word_t alu_result; // ALU to result stage
	logic alu_zero;
	logic alu_movn;
	logic alu_wen;
	logic alu_illegal;
	word_t mdu_result; // MDU to result stage
	logic mdu_done;
	logic mdu_div_zero;
	word_t result; // Result stage back to bus block
	word_t status;

	exec_if ops_if (); // Operands and starts

	apb_regs apb_regs_inst (
		.clk(clk),
		.rst(rst),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.issue(ops_if.issue),
		.result(result),
		.status(status)
	);

	alu alu_inst (
		.ops(ops_if.alu_side),
		.alu_result(alu_result),
		.alu_zero(alu_zero),
		.alu_movn(alu_movn),
		.alu_wen(alu_wen),
		.alu_illegal(alu_illegal)
	);

	mdu mdu_inst (
		.clk(clk),
		.rst(rst),
		.ops(ops_if.mdu_side),
		.mdu_result(mdu_result),
		.mdu_done(mdu_done),
		.mdu_div_zero(mdu_div_zero)
	);

	result_merge result_merge_inst (
		.clk(clk),
		.rst(rst),
		.obs(ops_if.observe),
		.alu_result(alu_result),
		.alu_zero(alu_zero),
		.alu_movn(alu_movn),
		.alu_wen(alu_wen),
		.alu_illegal(alu_illegal),
		.mdu_result(mdu_result),
		.mdu_done(mdu_done),
		.mdu_div_zero(mdu_div_zero),
		.result(result),
		.status(status)
	);

endmodule

// File: hw/mdu.sv
`timescale 1ns/1ps

module mdu import exec_pkg::*; (
	input logic clk,
	input logic rst,
	exec_if.mdu_side ops,
	output word_t mdu_result, // HI or LO for MFHI/MFLO
	output logic mdu_done, // One-cycle completion pulse
	output logic mdu_div_zero // Divide by zero, valid with mdu_done
);

	word_t hi_q;
	word_t lo_q;
	word_t acc_q; // Upper partial product or partial remainder
	word_t sh_q; // Multiplier shifting out, or dividend out and quotient in
	word_t opb_q; // Multiplicand or divisor magnitude
	op_t op_q; // Op in flight
	mdu_cnt_t cnt_q; // Steps taken
	logic busy_q;
	logic neg_q; // Negate product or quotient
	logic neg_rem_q; // Negate remainder, follows dividend sign
	logic dz_q; // Divide by zero pending

	logic is_signed;
	logic start_div;
	logic start_mf;
	logic a_neg;
	logic b_neg;
	word_t a_mag;
	word_t b_mag;
	logic [XLEN:0] add_sum; // Shift-add step sum with carry
	logic [XLEN:0] rem_shift; // Remainder shifted left by one dividend bit
	logic [XLEN:0] rem_diff; // Trial subtraction
	logic q_bit; // New quotient bit
	logic [2*XLEN-1:0] prod;

	always_comb begin
		is_signed = (ops.operation == OP_MULT) || (ops.operation == OP_DIV);
		start_div = (ops.operation == OP_DIV) || (ops.operation == OP_DIVU);
		start_mf = (ops.operation == OP_MFHI) || (ops.operation == OP_MFLO);
		a_neg = is_signed && ops.a[XLEN-1];
		b_neg = is_signed && ops.b[XLEN-1];
		a_mag = a_neg ? -ops.a : ops.a; // Iterate on magnitudes
		b_mag = b_neg ? -ops.b : ops.b;
	end

	assign add_sum = {1'b0, acc_q} + (sh_q[0] ? {1'b0, opb_q} : '0);
	assign rem_shift = {acc_q, sh_q[XLEN-1]};
	assign rem_diff = rem_shift - {1'b0, opb_q};
	assign q_bit = !rem_diff[XLEN]; // No borrow, subtraction fits
	assign prod = {acc_q, sh_q};

	assign mdu_done = busy_q && (cnt_q == mdu_cnt_t'(MDU_STEPS));
	assign mdu_div_zero = mdu_done && dz_q;
	assign mdu_result = (op_q == OP_MFHI) ? hi_q : lo_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			cnt_q <= '0;
			hi_q <= '0;
			lo_q <= '0;
		end else if (ops.mdu_start) begin
			busy_q <= 1'b1;
			// MFHI/MFLO and divide by zero skip the iterations
			if (start_mf || (start_div && (ops.b == '0)))
				cnt_q <= mdu_cnt_t'(MDU_STEPS);
			else
				cnt_q <= '0;
		end else if (mdu_done) begin
			busy_q <= 1'b0;
			if ((op_q == OP_MULT) || (op_q == OP_MULTU)) begin
				{hi_q, lo_q} <= neg_q ? -prod : prod;
			end else if (((op_q == OP_DIV) || (op_q == OP_DIVU)) && !dz_q) begin
				lo_q <= neg_q ? -sh_q : sh_q; // Quotient truncates toward zero
				hi_q <= neg_rem_q ? -acc_q : acc_q; // Remainder
			end
		end else if (busy_q) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (ops.mdu_start) begin
			op_q <= ops.operation;
			acc_q <= '0;
			sh_q <= a_mag;
			opb_q <= b_mag;
			neg_q <= a_neg ^ b_neg;
			neg_rem_q <= a_neg;
			dz_q <= start_div && (ops.b == '0);
		end else if (busy_q && !mdu_done) begin
			if ((op_q == OP_DIV) || (op_q == OP_DIVU)) begin // Restoring divide step
				acc_q <= q_bit ? rem_diff[XLEN-1:0] : rem_shift[XLEN-1:0];
				sh_q <= {sh_q[XLEN-2:0], q_bit};
			end else begin // Shift-add multiply step
				acc_q <= add_sum[XLEN:1];
				sh_q <= {add_sum[0], sh_q[XLEN-1:1]};
			end
		end
	end

	// Bus block must refuse CTRL writes until result stage drops busy
	a_no_overlap: assert property (@(posedge clk) disable iff (rst) ops.mdu_start |-> !busy_q)
		else $error("mdu_start while MDU operation running");

endmodule

// File: hw/result_merge.sv
`timescale 1ns/1ps

module result_merge import exec_pkg::*; (
	input logic clk,
	input logic rst,
	exec_if.observe obs,
	input word_t alu_result,
	input logic alu_zero,
	input logic alu_movn,
	input logic alu_wen,
	input logic alu_illegal,
	input word_t mdu_result,
	input logic mdu_done,
	input logic mdu_div_zero,
	output word_t result, // RESULT register
	output word_t status // STATUS register
);

	unit_e owner_q; // Unit that owns the pending result
	logic first_q; // Cycle right after an MDU start
	logic busy_q;
	logic zero_q;
	logic movn_q;
	logic err_q;
	logic done_q;
	word_t result_q;
	logic mdu_fin; // MDU completion for an op we started

	assign mdu_fin = mdu_done && (owner_q == UNIT_MDU);

	always_ff @(posedge clk) begin
		if (rst) begin
			owner_q <= UNIT_ALU;
			first_q <= 1'b0;
			busy_q <= 1'b0;
			zero_q <= 1'b0;
			movn_q <= 1'b0;
			err_q <= 1'b0;
			done_q <= 1'b0;
			result_q <= '0;
		end else begin
			first_q <= obs.mdu_start;
			if (obs.alu_start || obs.mdu_start)
				owner_q <= obs.unit;
			if (obs.alu_start) begin // ALU finishes in its start cycle
				zero_q <= alu_zero;
				movn_q <= alu_movn;
				err_q <= alu_illegal;
				done_q <= 1'b1;
				if (alu_wen)
					result_q <= alu_result;
			end else if (obs.mdu_start) begin
				busy_q <= 1'b1;
				done_q <= 1'b0;
				err_q <= 1'b0;
			end else if (mdu_fin) begin
				busy_q <= 1'b0;
				done_q <= 1'b1;
				err_q <= mdu_div_zero;
				// Only MFHI/MFLO finish one cycle after start without a div-zero flag
				if (first_q && !mdu_div_zero)
					result_q <= mdu_result;
			end
		end
	end

	always_comb begin
		status = '0;
		status[ST_BUSY] = busy_q;
		status[ST_ZERO] = zero_q;
		status[ST_MOVN] = movn_q;
		status[ST_ERROR] = err_q;
		status[ST_DONE] = done_q;
	end

	assign result = result_q;

	// Busy blocks new starts, so an ALU op cannot land on an MDU completion
	a_one_source: assert property (@(posedge clk) disable iff (rst)
		!(obs.alu_start && mdu_done))
		else $error("alu_start and mdu_done in the same cycle");

endmodule

// File: sources.f
+incdir+test
hw/exec_pkg.sv
hw/exec_if.sv
hw/apb_regs.sv
hw/alu.sv
hw/mdu.sv
hw/result_merge.sv
hw/exec_top.sv
test/exec_tb.sv

// File: test/exec_tb_tasks.svh
`ifndef EXEC_TB_TASKS_SVH
`define EXEC_TB_TASKS_SVH

// One APB transfer, setup then access, inputs change on the falling edge
task automatic apb_xfer(input logic wr, input addr_t addr, input word_t wdata,
		output word_t rdata, output logic err);
	@(negedge clk); // Setup phase
	psel = 1'b1;
	penable = 1'b0;
	pwrite = wr;
	paddr = addr;
	pwdata = wdata;
	@(negedge clk); // Access phase
	penable = 1'b1;
	@(posedge clk); // No wait states, access ends on this edge
	rdata = prdata;
	err = pslverr;
	@(negedge clk);
	psel = 1'b0; // Back to idle
	penable = 1'b0;
	pwrite = 1'b0;
endtask

task automatic apb_write(input addr_t addr, input word_t data, output logic err);
	word_t unused_rd;
	apb_xfer(1'b1, addr, data, unused_rd, err);
endtask

task automatic apb_read(input addr_t addr, output word_t data, output logic err);
	apb_xfer(1'b0, addr, '0, data, err);
endtask

// CTRL layout: op 4:0, shamt 12:8, equal 16
function automatic word_t ctrl_word(input op_t op, input shamt_t sh, input logic eq);
	word_t w;
	w = '0;
	w[4:0] = op;
	w[12:8] = sh;
	w[16] = eq;
	return w;
endfunction

// Arithmetic right shift by sign extension to 64 bits
function automatic word_t shift_arith(input word_t v, input shamt_t sh);
	logic [63:0] ext;
	ext = {{32{v[31]}}, v} >> sh;
	return ext[31:0];
endfunction

// Expected RESULT register after an ALU-class op
function automatic word_t alu_expect(input op_t op, input word_t a, input word_t b,
		input shamt_t sh);
	word_t r;
	case (op)
		OP_AND: r = a & b;
		OP_OR: r = a | b;
		OP_ADD, OP_ADDU: r = a + b; // Both wrap
		OP_MOVN: r = (b != '0) ? a : last_result; // No write when B is zero
		OP_SLL: r = b << sh;
		OP_SUB, OP_SUBU: r = a - b;
		OP_BGEZ: r = word_t'(!a[31]);
		OP_SLT: r = word_t'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)); // Bias to unsigned
		OP_SLTU: r = word_t'(a < b);
		OP_SRL: r = b >> sh;
		OP_NOR: r = ~(a | b);
		OP_XOR: r = a ^ b;
		OP_SRA: r = shift_arith(b, sh);
		OP_LUI: r = {b[15:0], 16'h0000};
		OP_SRAV: r = shift_arith(b, a[4:0]);
		default: r = DEADBEEF;
	endcase
	return r;
endfunction

// Expected STATUS word after an ALU-class op
function automatic word_t alu_status_expect(input op_t op, input word_t a, input word_t b,
		input logic eq);
	word_t st;
	st = '0;
	st[ST_DONE] = 1'b1;
	if (op == OP_SUB)
		st[ST_ZERO] = eq ? (a == b) : (a != b); // BEQ or BNE sense
	if (op == OP_BGEZ)
		st[ST_ZERO] = !a[31];
	if (op == OP_MOVN)
		st[ST_MOVN] = (b != '0);
	if (op > OP_MFLO)
		st[ST_ERROR] = 1'b1; // Undefined code
	return st;
endfunction

// HI/LO after a multiply or divide, unchanged on divide by zero
task automatic mdu_expect(input op_t op, input word_t a, input word_t b);
	longint sa;
	longint sb;
	logic [63:0] p;
	word_t ma;
	word_t mb;
	word_t q;
	word_t r;
	logic sgn;
	sgn = (op == OP_MULT) || (op == OP_DIV);
	sa = longint'($signed(a));
	sb = longint'($signed(b));
	ma = (sgn && a[31]) ? -a : a;
	mb = (sgn && b[31]) ? -b : b;
	if ((op == OP_MULT) || (op == OP_MULTU)) begin
		if (sgn)
			p = 64'(sa * sb);
		else
			p = {32'd0, a} * {32'd0, b};
		{model_hi, model_lo} = p;
	end else if (b != '0) begin
		q = ma / mb;
		r = ma % mb;
		model_lo = (sgn && (a[31] ^ b[31])) ? -q : q; // Truncates toward zero
		model_hi = (sgn && a[31]) ? -r : r; // Sign of dividend
	end
endtask

`endif

// File: test/exec_tb.sv
`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

	logic clk;
	logic rst;
	addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	word_t pwdata;
	word_t prdata;
	logic pready;
	logic pslverr;

	logic chk_en; // Compare strobe for the checker
	word_t chk_got;
	word_t chk_exp;
	string chk_msg;
	word_t last_result; // Model of the RESULT register
	word_t model_hi;
	word_t model_lo;

	`include "exec_tb_tasks.svh"

	exec_top exec_top_inst (
		.clk(clk),
		.rst(rst),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	// Every captured value is compared here
	a_value: assert property (@(posedge clk) chk_en |-> (chk_got == chk_exp))
		else begin
			$display("CHECK FAILED at %0t: %s, got %h, expected %h",
				$time, chk_msg, chk_got, chk_exp);
			$display("Checks failed");
			$fatal(1, "stopped at first mismatch");
		end

	// No wait states, so every access cycle completes
	a_pready: assert property (@(posedge clk) (psel && penable) |-> pready)
		else begin
			$display("CHECK FAILED at %0t: pready low in APB access phase", $time);
			$display("Checks failed");
			$fatal(1, "stopped at first mismatch");
		end

	initial begin
		repeat (400 * 40) @(posedge clk); // 400 ops, 40 cycles each
		$display("Timeout: the test sequence did not finish in time");
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

	// Present a value to the checker for one clock edge
	task automatic check_value(input word_t got, input word_t exp, input string msg);
		chk_got = got;
		chk_exp = exp;
		chk_msg = msg;
		chk_en = 1'b1;
		@(posedge clk);
		@(negedge clk);
		chk_en = 1'b0;
	endtask

	task automatic wait_idle(output word_t st);
		logic err;
		int polls;
		polls = 0;
		apb_read(REG_STATUS, st, err);
		while (st[ST_BUSY] && (polls < 60)) begin // Software polling
			apb_read(REG_STATUS, st, err);
			polls++;
		end
		if (st[ST_BUSY]) begin
			$display("MDU still busy after %0d status polls", polls);
			$display("Checks failed");
			$fatal(1, "MDU never finished");
		end
	endtask

	task automatic run_alu(input op_t op, input word_t a, input word_t b, input shamt_t sh,
			input logic eq);
		word_t got;
		word_t exp;
		logic err;
		apb_write(REG_A, a, err);
		apb_write(REG_B, b, err);
		apb_write(REG_CTRL, ctrl_word(op, sh, eq), err); // Starts the op
		exp = alu_expect(op, a, b, sh);
		apb_read(REG_RESULT, got, err);
		check_value(got, exp, $sformatf("RESULT of op %0d", op));
		last_result = exp;
		apb_read(REG_STATUS, got, err);
		check_value(got, alu_status_expect(op, a, b, eq), $sformatf("STATUS of op %0d", op));
	endtask

	// MFHI or MFLO and compare with the model register
	task automatic read_hilo(input op_t op, input word_t exp);
		word_t got;
		word_t st;
		logic err;
		apb_write(REG_CTRL, ctrl_word(op, '0, 1'b0), err);
		wait_idle(st);
		apb_read(REG_RESULT, got, err);
		check_value(got, exp, $sformatf("RESULT of move op %0d", op));
		last_result = exp;
	endtask

	task automatic run_mdu(input op_t op, input word_t a, input word_t b, input logic poke);
		word_t got;
		word_t st;
		logic err;
		logic dz;
		dz = ((op == OP_DIV) || (op == OP_DIVU)) && (b == '0);
		apb_write(REG_A, a, err);
		apb_write(REG_B, b, err);
		apb_write(REG_CTRL, ctrl_word(op, '0, 1'b0), err);
		if (!dz) begin // Divide by zero is over before the read
			apb_read(REG_STATUS, st, err);
			check_value(word_t'(st[ST_BUSY]), 32'd1, "busy after MDU start");
		end
		if (poke) begin // Writes while busy are refused
			apb_write(REG_A, ~a, err);
			check_value(word_t'(err), 32'd1, "pslverr on A write while busy");
			apb_write(REG_CTRL, ctrl_word(OP_ADD, '0, 1'b0), err);
			check_value(word_t'(err), 32'd1, "pslverr on CTRL write while busy");
		end
		wait_idle(st);
		check_value(word_t'(st[ST_DONE]), 32'd1, "done after MDU op");
		check_value(word_t'(st[ST_ERROR]), word_t'(dz), "error after MDU op");
		mdu_expect(op, a, b);
		read_hilo(OP_MFHI, model_hi);
		read_hilo(OP_MFLO, model_lo);
		if (poke) begin
			apb_read(REG_A, got, err);
			check_value(got, a, "A after refused write");
		end
	endtask

	initial begin
		word_t a;
		word_t b;
		logic err;
		void'($urandom(32'h7dda));
		rst = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		chk_en = 1'b0;
		chk_got = '0;
		chk_exp = '0;
		chk_msg = "";
		last_result = '0;
		model_hi = '0;
		model_lo = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		apb_read(REG_RESULT, a, err);
		check_value(a, '0, "RESULT after reset");
		apb_read(REG_STATUS, a, err);
		check_value(a, '0, "STATUS after reset");

		for (int op = 0; op <= 16; op++) begin // Whole ALU table
			repeat (4) run_alu(op_t'(op), $urandom, $urandom, shamt_t'($urandom), 1'($urandom));
		end

		b = $urandom;
		run_alu(OP_SUB, b, b, '0, 1'b1); // BEQ, equal operands
		run_alu(OP_SUB, b, ~b, '0, 1'b1);
		run_alu(OP_SUB, b, b, '0, 1'b0); // BNE
		run_alu(OP_SUB, b, ~b, '0, 1'b0);
		run_alu(OP_BGEZ, 32'h8000_0001, b, '0, 1'b0);
		run_alu(OP_BGEZ, 32'h7fff_ffff, b, '0, 1'b0);
		run_alu(OP_BGEZ, 32'h0000_0000, b, '0, 1'b0);
		run_alu(OP_MOVN, $urandom, 32'h0000_0001, '0, 1'b0);
		run_alu(OP_MOVN, $urandom, 32'h0000_0000, '0, 1'b0); // RESULT holds
		run_alu(5'd23, $urandom, $urandom, '0, 1'b0); // Undefined codes
		run_alu(5'd31, $urandom, $urandom, '0, 1'b0);

		run_mdu(OP_MULT, 32'hffff_fffd, 32'd7, 1'b0);
		run_mdu(OP_MULTU, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		run_mdu(OP_DIV, 32'hffff_fff9, 32'd2, 1'b0); // -7 / 2
		run_mdu(OP_DIV, 32'd7, 32'hffff_fffe, 1'b0); // 7 / -2
		run_mdu(OP_DIVU, 32'hffff_fff9, 32'd2, 1'b0);
		repeat (8) begin
			a = $urandom;
			b = $urandom;
			run_mdu(op_t'(OP_MULT + ($urandom % 4)), a, (b == '0) ? 32'd1 : b, 1'b0);
		end
		run_mdu(OP_DIV, $urandom, 32'd0, 1'b0); // HI/LO must stay
		run_mdu(OP_DIVU, $urandom, 32'd0, 1'b0);
		run_mdu(OP_MULT, $urandom, $urandom, 1'b1);

		$display("All checks passed");
		$finish;
	end

endmodule
